/* project.f */
source/noc_pkg.sv
source/router_pkg.sv
source/router_input_port.sv
source/router_crossbar.sv
source/router_output_arbiter.sv
source/mesh_router.sv
test/router_checker.sv
test/tb_mesh_router.sv

/* test/tb_mesh_router.sv */
// Mesh router testbench
`timescale 1ns/1ps

module tb_mesh_router
  import noc_pkg::*;
  import router_pkg::*;
();

  // Output ready behaviour of a test
  localparam int ReadyAlways = 0;
  localparam int ReadyRandom = 1;
  localparam int ReadyStall  = 2;
  localparam int MaxRows     = 32;

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  coord_t               router_x_i;
  coord_t               router_y_i;
  logic  [NumPorts-1:0] in_valid_i;
  logic  [NumPorts-1:0] in_ready_o;
  flit_t [NumPorts-1:0] in_data_i;
  logic  [NumPorts-1:0] out_valid_o;
  logic  [NumPorts-1:0] out_ready_i;
  flit_t [NumPorts-1:0] out_data_o;

  // Checker side band
  logic       test_done;
  logic       stall_test;
  logic [2:0] expect_port;
  int         err_count;
  int         pending;

  // Stimulus table, one row per test
  int row_src [MaxRows];
  int row_dx [MaxRows];
  int row_dy [MaxRows];
  int row_rx [MaxRows];
  int row_ry [MaxRows];
  int row_count [MaxRows];
  int row_mode [MaxRows];
  int row_port [MaxRows];
  int num_rows = 0;

  integer seed = 32'he75a08ab;
  int cycles = 0;
  int limit = 0;
  int total_flits = 0;

  always #4 clk_i = ~clk_i;

  mesh_router mesh_router_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .router_x_i  (router_x_i),
    .router_y_i  (router_y_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

  router_checker router_checker_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .router_x_i    (router_x_i),
    .router_y_i    (router_y_i),
    .in_valid_i    (in_valid_i),
    .in_ready_i    (in_ready_o),
    .in_data_i     (in_data_i),
    .out_valid_i   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_data_i    (out_data_o),
    .expect_port_i (expect_port),
    .stall_test_i  (stall_test),
    .test_done_i   (test_done),
    .err_count_o   (err_count),
    .pending_o     (pending)
  );

  // Append one test to the table
  task automatic add_row(input int src, dx, dy, rx, ry, count, mode, port);
    row_src[num_rows]   = src;
    row_dx[num_rows]    = dx;
    row_dy[num_rows]    = dy;
    row_rx[num_rows]    = rx;
    row_ry[num_rows]    = ry;
    row_count[num_rows] = count;
    row_mode[num_rows]  = mode;
    row_port[num_rows]  = port;
    num_rows++;
  endtask

  // Output ready for one cycle, the stall lasts 20 cycles
  task automatic drive_out_ready(input int mode, input int cycle);
    int r;
    for (int o = 0; o < NumPorts; o++) begin
      r = $random(seed);
      case (mode)
        ReadyRandom: out_ready_i[o] = r[0];
        ReadyStall:  out_ready_i[o] = (cycle >= 20);
        default:     out_ready_i[o] = 1'b1;
      endcase
    end
  endtask

  // Apply one row and wait until its flits have drained
  task automatic run_row(input int t);
    int sent [NumPorts];
    int flits;
    int accepted;
    int cycle;
    int start_err;
    logic [NumPorts-1:0] took;
    logic busy;
    payload_t payload;
    flits       = row_count[t] * $countones(row_src[t]);
    start_err   = err_count;
    router_x_i  = coord_t'(row_rx[t]);
    router_y_i  = coord_t'(row_ry[t]);
    stall_test  = (row_mode[t] == ReadyStall);
    expect_port = 3'(row_port[t]);
    for (int s = 0; s < NumPorts; s++) begin
      sent[s] = 0;
    end
    accepted = 0;
    cycle    = 0;
    busy     = 1'b1;
    while (busy) begin
      // Payload carries source port, test index and sequence number
      for (int s = 0; s < NumPorts; s++) begin
        payload       = {4'(s), 8'(t), 16'(sent[s])};
        in_valid_i[s] = row_src[t][s] && (sent[s] < row_count[t]);
        in_data_i[s]  = {coord_t'(row_dx[t]), coord_t'(row_dy[t]), payload};
      end
      drive_out_ready(row_mode[t], cycle);
      @(posedge clk_i);
      took = in_valid_i & in_ready_o;
      @(negedge clk_i);
      for (int s = 0; s < NumPorts; s++) begin
        if (took[s]) begin
          sent[s]++;
        end
      end
      accepted += $countones(took);
      cycle++;
      busy = (pending != 0) || (accepted < flits);
    end
    in_valid_i  = '0;
    out_ready_i = '1;
    test_done   = 1'b1;
    @(negedge clk_i);
    test_done = 1'b0;
    $display("Test %0d: inputs %b to (%0d,%0d) at router (%0d,%0d), %0d flits, %0d errors",
             t, 5'(row_src[t]), row_dx[t], row_dy[t], row_rx[t], row_ry[t], flits,
             err_count - start_err);
  endtask

  // Run length guard
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    reset_i     = 1'b1;
    router_x_i  = '0;
    router_y_i  = '0;
    in_valid_i  = '0;
    in_data_i   = '0;
    out_ready_i = '1;
    test_done   = 1'b0;
    stall_test  = 1'b0;
    expect_port = '0;
    // Sources, destination, router position, count, ready mode, expected port
    add_row(5'b00001, 1, 1, 1, 1, 3, ReadyAlways, PortLocal);
    add_row(5'b00001, 3, 0, 1, 1, 4, ReadyRandom, PortEast);
    add_row(5'b00001, 0, 3, 2, 2, 4, ReadyAlways, PortWest);
    add_row(5'b00001, 1, 3, 1, 1, 3, ReadyAlways, PortNorth);
    add_row(5'b00001, 1, 0, 1, 2, 3, ReadyRandom, PortSouth);
    add_row(5'b00010, 2, 0, 2, 2, 5, ReadyRandom, PortSouth);
    add_row(5'b01000, 0, 3, 0, 1, 3, ReadyAlways, PortNorth);
    add_row(5'b00100, 0, 1, 2, 1, 4, ReadyAlways, PortWest);
    add_row(5'b10000, 3, 3, 1, 3, 4, ReadyRandom, PortEast);
    add_row(5'b10000, 3, 0, 3, 0, 3, ReadyAlways, PortLocal);
    add_row(5'b00100, 2, 3, 2, 0, 3, ReadyAlways, PortNorth);
    add_row(5'b00010, 0, 3, 0, 3, 3, ReadyRandom, PortLocal);
    add_row(5'b00100, 1, 0, 1, 2, 3, ReadyAlways, PortSouth);
    // Ordering under random ready, then stalls and contention
    add_row(5'b00001, 3, 1, 1, 1, 8, ReadyRandom, PortEast);
    add_row(5'b00001, 2, 3, 2, 1, 6, ReadyStall, PortNorth);
    add_row(5'b10001, 3, 1, 1, 1, 8, ReadyAlways, PortEast);
    add_row(5'b01010, 2, 2, 2, 2, 6, ReadyAlways, PortLocal);
    add_row(5'b10101, 1, 3, 1, 1, 4, ReadyStall, PortNorth);
    add_row(5'b00101, 1, 0, 1, 2, 5, ReadyRandom, PortSouth);
    for (int t = 0; t < num_rows; t++) begin
      total_flits += row_count[t] * $countones(row_src[t]);
    end
    limit = 40 * total_flits + 200;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (2) @(negedge clk_i);
    for (int t = 0; t < num_rows; t++) begin
      run_row(t);
    end
    $display("%0d tests, %0d flits, %0d errors", num_rows, total_flits, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* test/router_checker.sv */
// Router output scoreboard
`timescale 1ns/1ps

module router_checker
  import noc_pkg::*;
  import router_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  coord_t               router_x_i,
  input  coord_t               router_y_i,
  input  logic  [NumPorts-1:0] in_valid_i,
  input  logic  [NumPorts-1:0] in_ready_i,
  input  flit_t [NumPorts-1:0] in_data_i,
  input  logic  [NumPorts-1:0] out_valid_i,
  input  logic  [NumPorts-1:0] out_ready_i,
  input  flit_t [NumPorts-1:0] out_data_i,
  input  logic  [2:0]          expect_port_i,
  input  logic                 stall_test_i,
  input  logic                 test_done_i,
  output int                   err_count_o,
  output int                   pending_o
);

  // Expected flits per input and output pair
  localparam int Slots = 64;

  flit_t exp_mem [NumPorts][NumPorts][Slots];
  int    wr_cnt [NumPorts][NumPorts];
  int    rd_cnt [NumPorts][NumPorts];

  // Last winner per output, and a rival queued at that moment
  int    last_src [NumPorts];
  logic  rival_waiting [NumPorts];

  // Output held by a low ready in the previous cycle
  logic  held [NumPorts];
  flit_t held_data [NumPorts];

  logic  in_reset;
  logic  ready_fell;

  // XY rule, x settled before y
  function automatic int xy_port(flit_t flit);
    coord_t dx;
    coord_t dy;
    dx = flit[FlitWidth-1 -: CoordWidth];
    dy = flit[FlitWidth-CoordWidth-1 -: CoordWidth];
    if (dx > router_x_i) return PortEast;
    if (dx < router_x_i) return PortWest;
    if (dy > router_y_i) return PortNorth;
    if (dy < router_y_i) return PortSouth;
    return PortLocal;
  endfunction

  // Pop the queue head that this output flit belongs to
  task automatic match_output(input int o);
    int src;
    int win;
    // Source port sits in the top payload bits
    src = out_data_i[o][PayloadWidth-1 -: 4];
    win = -1;
    for (int s = 0; s < NumPorts; s++) begin
      if (win < 0 && rd_cnt[s][o] < wr_cnt[s][o] &&
          exp_mem[s][o][rd_cnt[s][o] % Slots] === out_data_i[o]) begin
        win = s;
      end
    end
    if (win < 0 && src < NumPorts && rd_cnt[src][o] < wr_cnt[src][o]) begin
      $display("ERR out_data_o[%0d] = %h, expected %h", o, out_data_i[o],
               exp_mem[src][o][rd_cnt[src][o] % Slots]);
      err_count_o++;
      win = src;
    end
    if (win < 0) begin
      $display("Output %0d delivered flit %h that no input sent there", o, out_data_i[o]);
      err_count_o++;
    end else begin
      rd_cnt[win][o]++;
      // Round robin never repeats a winner over a queued rival
      if (win == last_src[o] && rival_waiting[o]) begin
        $display("Input %0d won output %0d twice while another input waited", win, o);
        err_count_o++;
      end
      last_src[o]      = win;
      rival_waiting[o] = 1'b0;
      for (int s = 0; s < NumPorts; s++) begin
        if (s != win && rd_cnt[s][o] < wr_cnt[s][o]) begin
          rival_waiting[o] = 1'b1;
        end
      end
    end
    if (o != int'(expect_port_i)) begin
      $display("Flit %h left on port %0d but the table expects port %0d",
               out_data_i[o], o, expect_port_i);
      err_count_o++;
    end
  endtask

  // End of test, nothing may stay in flight
  task automatic close_test();
    for (int s = 0; s < NumPorts; s++) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (rd_cnt[s][o] != wr_cnt[s][o]) begin
          $display("Output %0d never delivered %0d flit(s) from input %0d",
                   o, wr_cnt[s][o] - rd_cnt[s][o], s);
          err_count_o++;
        end
        rd_cnt[s][o] = 0;
        wr_cnt[s][o] = 0;
      end
      last_src[s]      = -1;
      rival_waiting[s] = 1'b0;
    end
    if (stall_test_i && !ready_fell) begin
      $display("in_ready_o stayed high through the whole output stall");
      err_count_o++;
    end
    ready_fell = 1'b0;
  endtask

  always @(posedge clk_i) begin : scoreboard
    int dst;
    if (reset_i) begin
      in_reset    = 1'b1;
      ready_fell  = 1'b0;
      err_count_o = 0;
      pending_o   = 0;
      for (int s = 0; s < NumPorts; s++) begin
        for (int o = 0; o < NumPorts; o++) begin
          wr_cnt[s][o] = 0;
          rd_cnt[s][o] = 0;
        end
        last_src[s]      = -1;
        rival_waiting[s] = 1'b0;
        held[s]          = 1'b0;
      end
    end else begin
      // First edge out of reset
      if (in_reset) begin
        in_reset = 1'b0;
        if (out_valid_i != '0) begin
          $display("ERR out_valid_o = %h, expected 00", out_valid_i);
          err_count_o++;
        end
        if (in_ready_i != '1) begin
          $display("ERR in_ready_o = %h, expected 1f", in_ready_i);
          err_count_o++;
        end
      end
      for (int o = 0; o < NumPorts; o++) begin
        // A stalled output keeps valid and data
        if (held[o] && !out_valid_i[o]) begin
          $display("ERR out_valid_o[%0d] = 0, expected 1", o);
          err_count_o++;
        end else if (held[o] && out_data_i[o] !== held_data[o]) begin
          $display("ERR out_data_o[%0d] = %h, expected %h", o, out_data_i[o], held_data[o]);
          err_count_o++;
        end
        if (out_valid_i[o] && out_ready_i[o]) begin
          match_output(o);
        end
        held[o]      = out_valid_i[o] & ~out_ready_i[o];
        held_data[o] = out_data_i[o];
      end
      // Inputs are queued after outputs, a new flit cannot leave on the same edge
      for (int s = 0; s < NumPorts; s++) begin
        if (in_valid_i[s] && in_ready_i[s]) begin
          dst = xy_port(in_data_i[s]);
          exp_mem[s][dst][wr_cnt[s][dst] % Slots] = in_data_i[s];
          wr_cnt[s][dst]++;
        end
      end
      if (in_ready_i != '1) begin
        ready_fell = 1'b1;
      end
      if (test_done_i) begin
        close_test();
      end
      pending_o = 0;
      for (int s = 0; s < NumPorts; s++) begin
        for (int o = 0; o < NumPorts; o++) begin
          pending_o += wr_cnt[s][o] - rd_cnt[s][o];
        end
      end
    end
  end

endmodule

/* source/mesh_router.sv */
// Five-port XY mesh router
`timescale 1ns/1ps

module mesh_router
  import noc_pkg::*;
  import router_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Own position in the mesh
  input  coord_t               router_x_i,
  input  coord_t               router_y_i,
  // Input streams, indexed by port_e
  input  logic  [NumPorts-1:0] in_valid_i,
  output logic  [NumPorts-1:0] in_ready_o,
  input  flit_t [NumPorts-1:0] in_data_i,
  // Output streams, indexed by port_e
  output logic  [NumPorts-1:0] out_valid_o,
  input  logic  [NumPorts-1:0] out_ready_i,
  output flit_t [NumPorts-1:0] out_data_o
);

  // FIFO heads toward the crossbar
  logic       [NumPorts-1:0] req_valid;
  port_mask_t [NumPorts-1:0] req_route;
  flit_t      [NumPorts-1:0] req_data;
  logic       [NumPorts-1:0] req_ready;

  // Crossbar to arbiters
  port_mask_t [NumPorts-1:0] grant;
  port_mask_t [NumPorts-1:0] out_req;
  flit_t      [NumPorts-1:0] xbar_data;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    router_input_port router_input_port_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .router_x_i  (router_x_i),
      .router_y_i  (router_y_i),
      .in_valid_i  (in_valid_i[i]),
      .in_ready_o  (in_ready_o[i]),
      .in_data_i   (in_data_i[i]),
      .req_valid_o (req_valid[i]),
      .req_route_o (req_route[i]),
      .req_data_o  (req_data[i]),
      .req_ready_i (req_ready[i])
    );
  end

  router_crossbar router_crossbar_inst (
    .req_valid_i (req_valid),
    .req_route_i (req_route),
    .req_data_i  (req_data),
    .req_ready_o (req_ready),
    .grant_i     (grant),
    .out_req_o   (out_req),
    .out_data_o  (xbar_data)
  );

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    router_output_arbiter router_output_arbiter_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (out_req[o]),
      .data_i      (xbar_data),
      .grant_o     (grant[o]),
      .out_valid_o (out_valid_o[o]),
      .out_ready_i (out_ready_i[o]),
      .out_data_o  (out_data_o[o])
    );
  end

endmodule

/* source/router_output_arbiter.sv */
// Round-robin output arbiter
`timescale 1ns/1ps

module router_output_arbiter
  import noc_pkg::*;
  import router_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  port_mask_t           req_i,
  input  flit_t [NumPorts-1:0] data_i,
  output port_mask_t           grant_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output flit_t                out_data_o
);

  // Output register
  logic  valid_q;
  flit_t data_q;

  // Priority pointer, first port checked
  port_e ptr_q;

  logic  load_en;
  logic  found;
  logic  any_grant;
  port_e winner;

  // Register empty or draining this cycle
  assign load_en = ~valid_q | out_ready_i;

  // Search from the pointer, wrapping around the ports
  always_comb begin
    int idx;
    winner = ptr_q;
    found  = 1'b0;
    for (int k = 0; k < NumPorts; k++) begin
      idx = (int'(ptr_q) + k) % NumPorts;
      if (!found && req_i[idx]) begin
        found  = 1'b1;
        winner = port_e'(idx);
      end
    end
  end

  assign any_grant = found & load_en;

  // Grant one-hot, silent while the register is stuck
  always_comb begin
    grant_o = '0;
    if (any_grant) begin
      grant_o[winner] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      ptr_q   <= PortLocal;
    end else begin
      if (load_en) begin
        valid_q <= any_grant;
      end
      // Next search starts just after the winner
      if (any_grant) begin
        if (winner == port_e'(NumPorts - 1)) begin
          ptr_q <= PortLocal;
        end else begin
          ptr_q <= port_e'(winner + 1'b1);
        end
      end
    end
  end

  // Payload loads on the same edge as the input handshake
  always_ff @(posedge clk_i) begin
    if (any_grant) begin
      data_q <= data_i[winner];
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

/* source/router_crossbar.sv */
// Pruned XY router crossbar
`timescale 1ns/1ps

module router_crossbar
  import noc_pkg::*;
  import router_pkg::*;
(
  // Input side, one entry per input port
  input  logic       [NumPorts-1:0] req_valid_i,
  input  port_mask_t [NumPorts-1:0] req_route_i,
  input  flit_t      [NumPorts-1:0] req_data_i,
  output logic       [NumPorts-1:0] req_ready_o,
  // Output side, one entry per output port
  input  port_mask_t [NumPorts-1:0] grant_i,
  output port_mask_t [NumPorts-1:0] out_req_o,
  // Head flits, shared by every arbiter
  output flit_t      [NumPorts-1:0] out_data_o
);

  // Grant seen by each input, transposed to input-major
  port_mask_t [NumPorts-1:0] grant_t;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    for (genvar o = 0; o < NumPorts; o++) begin : gen_out
      // XY never turns from Y to X and never bounces back on a mesh port
      // Local to Local stays so a core can reach itself
      if ((i == o && i != PortLocal) ||
          ((i == PortNorth || i == PortSouth) && (o == PortEast || o == PortWest)))
      begin : gen_no_conn
        assign out_req_o[o][i] = 1'b0;
        assign grant_t[i][o]   = 1'b0;
      end else begin : gen_conn
        assign out_req_o[o][i] = req_valid_i[i] & req_route_i[i][o];
        assign grant_t[i][o]   = grant_i[o][i];
      end
    end

    // Ready only from the output this head is routed to
    assign req_ready_o[i] = |(grant_t[i] & req_route_i[i]);

    // Data goes to all arbiters, the grant picks the word
    assign out_data_o[i] = req_data_i[i];
  end

endmodule

/* source/router_input_port.sv */
// Router input buffer and route compute
`timescale 1ns/1ps

module router_input_port
  import noc_pkg::*;
  import router_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  coord_t     router_x_i,
  input  coord_t     router_y_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  flit_t      in_data_i,
  output logic       req_valid_o,
  output port_mask_t req_route_o,
  output flit_t      req_data_o,
  input  logic       req_ready_i
);

  // FIFO storage, no reset on payload
  flit_t mem_q [InFifoDepth];

  logic [InPtrWidth-1:0] wr_ptr_q;
  logic [InPtrWidth-1:0] rd_ptr_q;
  logic [InCntWidth-1:0] count_q;

  logic   push;
  logic   pop;
  flit_t  head_data;
  coord_t dst_x;
  coord_t dst_y;

  // Full only when every entry holds a flit
  assign in_ready_o = (count_q != InCntWidth'(InFifoDepth));
  assign push       = in_valid_i & in_ready_o;

  // Head is valid as soon as one entry is filled
  assign req_valid_o = (count_q != '0);
  assign pop         = req_valid_o & req_ready_i;

  assign head_data  = mem_q[rd_ptr_q];
  assign req_data_o = head_data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at the last entry
      if (push) begin
        if (wr_ptr_q == InPtrWidth'(InFifoDepth - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_q == InPtrWidth'(InFifoDepth - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Simultaneous push and pop leaves the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  assign dst_x = flit_dst_x(head_data);
  assign dst_y = flit_dst_y(head_data);

  // XY routing, resolve x fully before y
  always_comb begin
    req_route_o = '0;
    if (dst_x > router_x_i) begin
      req_route_o[PortEast] = 1'b1;
    end else if (dst_x < router_x_i) begin
      req_route_o[PortWest] = 1'b1;
    end else if (dst_y > router_y_i) begin
      req_route_o[PortNorth] = 1'b1;
    end else if (dst_y < router_y_i) begin
      req_route_o[PortSouth] = 1'b1;
    end else begin
      // Arrived, eject to the core
      req_route_o[PortLocal] = 1'b1;
    end
  end

endmodule

/* source/router_pkg.sv */
// Router port constants
package router_pkg;

  // Local plus four mesh directions
  localparam int unsigned NumPorts = 5;

  // Port numbering, also the bit index of a route mask
  // North is larger y, East is larger x
  typedef enum logic [2:0] {
    PortLocal = 3'd0,
    PortNorth = 3'd1,
    PortEast  = 3'd2,
    PortSouth = 3'd3,
    PortWest  = 3'd4
  } port_e;

  // One-hot route or grant, indexed by port_e
  typedef logic [NumPorts-1:0] port_mask_t;

  // Input buffer depth per port
  localparam int unsigned InFifoDepth = 2;

  // Read and write pointer width of the input FIFO
  localparam int unsigned InPtrWidth = (InFifoDepth > 1) ? $clog2(InFifoDepth) : 1;

  // Fill count width, must hold the full value
  localparam int unsigned InCntWidth = $clog2(InFifoDepth + 1);

endpackage

/* source/noc_pkg.sv */
// Network flit format
package noc_pkg;

  // Whole flit and its fields
  localparam int unsigned FlitWidth    = 32;
  localparam int unsigned CoordWidth   = 2;
  localparam int unsigned PayloadWidth = FlitWidth - 2 * CoordWidth;

  // Field positions, destination x sits on top
  localparam int unsigned DstXLsb = FlitWidth - CoordWidth;
  localparam int unsigned DstYLsb = DstXLsb - CoordWidth;

  // One mesh coordinate, 4x4 mesh
  typedef logic [CoordWidth-1:0]   coord_t;
  // Single-flit packet
  typedef logic [FlitWidth-1:0]    flit_t;
  // Data carried below the header bits
  typedef logic [PayloadWidth-1:0] payload_t;

  // Destination x of a flit
  function automatic coord_t flit_dst_x(flit_t flit);
    return flit[DstXLsb +: CoordWidth];
  endfunction

  // Destination y of a flit
  function automatic coord_t flit_dst_y(flit_t flit);
    return flit[DstYLsb +: CoordWidth];
  endfunction

  // Build a flit from its fields
  function automatic flit_t flit_pack(coord_t dst_x, coord_t dst_y, payload_t payload);
    return {dst_x, dst_y, payload};
  endfunction

  // Payload field of a flit
  function automatic payload_t flit_payload(flit_t flit);
    return flit[PayloadWidth-1:0];
  endfunction

endpackage
